// File: Makefile
# Verilator build and run for the buck control testbench

VERILATOR       ?= verilator
TOP             ?= buck_control_tb
FILELIST        ?= tb.f
BUILD_DIR       ?= obj_dir
LOG             ?= sim.log
FAIL_PATTERN    ?= Simulation failed
VERILATOR_FLAGS ?= --binary --timing --assert -Wno-fatal

SOURCES    := $(shell grep -v '^+' $(FILELIST))
SIM_BINARY := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BINARY)

$(SIM_BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BINARY)
	@./$(SIM_BINARY) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_PATTERN)" $(LOG); then \
		echo "Run reported a failure, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hw/buck_control_top.sv
// Buck control top level
`timescale 1ns/10ps

module buck_control_top (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          start,
    input  logic                          stop,
    input  logic                          update,
    input  logic                          config_done,
    input  buck_pkg::setpoint_t           setpoint,
    input  buck_pkg::phase_word_array_t   duty_adjust,
    input  buck_pkg::phase_word_array_t   phase_shifts,
    output logic                          modulator_status,
    output logic                          busy,
    output logic                          modulator_on,
    output pwm_map_pkg::pwm_phase_regs_t  phase_regs
);

    buck_pkg::phase_word_array_t phase_duties;
    pwm_map_pkg::pwm_write_t     write;
    logic                        write_valid;
    logic                        write_ready;

    phase_duty_calc duty_calc (
        .clock        (clock),
        .reset        (reset),
        .setpoint     (setpoint),
        .duty_adjust  (duty_adjust),
        .phase_duties (phase_duties)
    );

    operating_sequencer sequencer (
        .clock            (clock),
        .reset            (reset),
        .start            (start),
        .stop             (stop),
        .update           (update),
        .config_done      (config_done),
        .setpoint         (setpoint),
        .phase_shifts     (phase_shifts),
        .phase_duties     (phase_duties),
        .write            (write),
        .write_valid      (write_valid),
        .write_ready      (write_ready),
        .modulator_status (modulator_status),
        .busy             (busy)
    );

    pwm_register_bank register_bank (
        .clock        (clock),
        .reset        (reset),
        .write        (write),
        .write_valid  (write_valid),
        .write_ready  (write_ready),
        .phase_regs   (phase_regs),
        .modulator_on (modulator_on)
    );

endmodule

// File: hw/buck_pkg.sv
// Buck converter definitions
package buck_pkg;

    //////////////////////////////////////////////////////////////////////
    // Phase count
    //////////////////////////////////////////////////////////////////////

    // Number of interleaved phases in the converter
    localparam int n_phases = 4;

    // Counter that walks over the phases during a write sequence
    typedef logic [$clog2(n_phases)-1:0] phase_index_t;

    // Highest phase index, where a per-phase write run ends
    localparam phase_index_t last_phase_index = phase_index_t'(n_phases - 1);

    //////////////////////////////////////////////////////////////////////
    // Setpoint
    //////////////////////////////////////////////////////////////////////

    // Period and duty shared by all phases
    typedef struct packed {
        logic [15:0] period;
        logic [15:0] duty;
    } setpoint_t;

    // One 16-bit word per phase
    // Duty adjustments travel in this type too and are read as signed
    typedef logic [n_phases-1:0][15:0] phase_word_array_t;

    //////////////////////////////////////////////////////////////////////
    // Sequencer states
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        idle,
        wait_configuration,
        write_phase_shift,
        write_period,
        write_duty,
        write_enable,
        wait_write_end
    } operating_state_t;

endpackage

// File: hw/operating_sequencer.sv
// Operating write sequencer
`timescale 1ns/10ps

module operating_sequencer (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         start,
    input  logic                         stop,
    input  logic                         update,
    input  logic                         config_done,
    input  buck_pkg::setpoint_t          setpoint,
    input  buck_pkg::phase_word_array_t  phase_shifts,
    input  buck_pkg::phase_word_array_t  phase_duties,
    output pwm_map_pkg::pwm_write_t      write,
    output logic                         write_valid,
    input  logic                         write_ready,
    output logic                         modulator_status,
    output logic                         busy
);

    buck_pkg::operating_state_t state;
    buck_pkg::operating_state_t resume_state;
    buck_pkg::phase_index_t     phase_count;
    logic                       start_needed;
    logic                       stop_latched;
    logic                       stop_pending;
    logic                       transfer;
    logic                       last_phase;

    // Address of a register inside the block of the given phase
    function automatic logic [31:0] phase_address(
        input logic [31:0]            offset,
        input buck_pkg::phase_index_t index
    );
        logic [31:0] block_number;
        block_number = 32'(index) + 32'd1;
        return pwm_map_pkg::pwm_base_address
             + block_number * pwm_map_pkg::phase_block_stride + offset;
    endfunction

    assign transfer = write_valid && write_ready;
    assign last_phase = (phase_count == buck_pkg::last_phase_index);

    // A stop seen in idle is served at once, otherwise it waits in the latch
    assign stop_pending = stop || stop_latched;

    assign busy = (state != buck_pkg::idle);

    //////////////////////////////////////////////////////////////////////
    // Sequence FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= buck_pkg::idle;
            resume_state <= buck_pkg::idle;
            phase_count <= '0;
            start_needed <= 1'b0;
            stop_latched <= 1'b0;
            modulator_status <= 1'b0;
            write_valid <= 1'b0;
        end else begin
            if (stop) begin
                stop_latched <= 1'b1;
            end

            case (state)
                buck_pkg::idle: begin
                    // Stop has priority, then start, then update
                    if (stop_pending) begin
                        write.address <= pwm_map_pkg::control_address;
                        write.data <= '0;
                        write_valid <= 1'b1;
                        modulator_status <= 1'b0;
                        stop_latched <= 1'b0;
                        resume_state <= buck_pkg::idle;
                        state <= buck_pkg::wait_write_end;
                    end else if (start) begin
                        start_needed <= 1'b1;
                        phase_count <= '0;
                        state <= buck_pkg::wait_configuration;
                    end else if (update && modulator_status) begin
                        start_needed <= 1'b0;
                        phase_count <= '0;
                        state <= buck_pkg::write_period;
                    end
                end

                buck_pkg::wait_configuration: begin
                    if (config_done) begin
                        state <= buck_pkg::write_phase_shift;
                    end
                end

                // Each write state loads one write, and the bus is always free here
                buck_pkg::write_phase_shift: begin
                    write.address <= phase_address(pwm_map_pkg::phase_shift_offset, phase_count);
                    write.data <= phase_shifts[phase_count];
                    write_valid <= 1'b1;
                    if (last_phase) begin
                        phase_count <= '0;
                        resume_state <= buck_pkg::write_period;
                    end else begin
                        phase_count <= phase_count + 1'b1;
                        resume_state <= buck_pkg::write_phase_shift;
                    end
                    state <= buck_pkg::wait_write_end;
                end

                buck_pkg::write_period: begin
                    write.address <= phase_address(pwm_map_pkg::period_offset, phase_count);
                    write.data <= setpoint.period;
                    write_valid <= 1'b1;
                    if (last_phase) begin
                        phase_count <= '0;
                        resume_state <= buck_pkg::write_duty;
                    end else begin
                        phase_count <= phase_count + 1'b1;
                        resume_state <= buck_pkg::write_period;
                    end
                    state <= buck_pkg::wait_write_end;
                end

                buck_pkg::write_duty: begin
                    write.address <= phase_address(pwm_map_pkg::duty_offset, phase_count);
                    write.data <= phase_duties[phase_count];
                    write_valid <= 1'b1;
                    if (last_phase) begin
                        phase_count <= '0;
                        // Only a start sequence ends with the enable write
                        if (start_needed) begin
                            resume_state <= buck_pkg::write_enable;
                        end else begin
                            resume_state <= buck_pkg::idle;
                        end
                    end else begin
                        phase_count <= phase_count + 1'b1;
                        resume_state <= buck_pkg::write_duty;
                    end
                    state <= buck_pkg::wait_write_end;
                end

                buck_pkg::write_enable: begin
                    write.address <= pwm_map_pkg::control_address;
                    write.data <= pwm_map_pkg::modulator_on_word;
                    write_valid <= 1'b1;
                    resume_state <= buck_pkg::idle;
                    state <= buck_pkg::wait_write_end;
                end

                buck_pkg::wait_write_end: begin
                    if (transfer) begin
                        write_valid <= 1'b0;
                        state <= resume_state;
                        // The enable write is the only one that returns to idle
                        // with start_needed still set
                        if (resume_state == buck_pkg::idle && start_needed) begin
                            modulator_status <= 1'b1;
                            start_needed <= 1'b0;
                        end
                    end
                end

                default: begin
                    state <= buck_pkg::idle;
                end
            endcase
        end
    end

endmodule

// File: hw/phase_duty_calc.sv
// Per-phase duty calculator
`timescale 1ns/10ps

module phase_duty_calc (
    input  logic                         clock,
    input  logic                         reset,
    input  buck_pkg::setpoint_t          setpoint,
    input  buck_pkg::phase_word_array_t  duty_adjust,
    output buck_pkg::phase_word_array_t  phase_duties
);

    // Two extra bits hold both the carry out of 16 bits and the sign
    logic signed [17:0] duty_sum [buck_pkg::n_phases];
    buck_pkg::phase_word_array_t clamped_duties;

    //////////////////////////////////////////////////////////////////////
    // Signed sum and saturation
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int p = 0; p < buck_pkg::n_phases; p++) begin
            duty_sum[p] = $signed({2'b00, setpoint.duty})
                        + $signed({{2{duty_adjust[p][15]}}, duty_adjust[p]});

            if (duty_sum[p] < 0) begin
                clamped_duties[p] = 16'h0000;
            end else if (duty_sum[p] > $signed(18'h0FFFF)) begin
                clamped_duties[p] = 16'hFFFF;
            end else begin
                clamped_duties[p] = duty_sum[p][15:0];
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Output register
    //////////////////////////////////////////////////////////////////////

    // Duties follow the inputs one cycle later
    always_ff @(posedge clock) begin
        if (!reset) begin
            phase_duties <= '0;
        end else begin
            phase_duties <= clamped_duties;
        end
    end

endmodule

// File: hw/pwm_map_pkg.sv
// Modulator register map
package pwm_map_pkg;

    //////////////////////////////////////////////////////////////////////
    // Address layout
    //////////////////////////////////////////////////////////////////////

    // The control register sits at the very start of the space
    localparam logic [31:0] pwm_base_address = 32'h0000_0000;
    localparam logic [31:0] control_address = pwm_base_address;

    // Phase p owns the block at base + (p + 1) * stride
    localparam logic [31:0] phase_block_stride = 32'h0000_0100;

    // Byte offsets inside one phase block
    localparam logic [31:0] duty_offset = 32'h0000_0002;
    localparam logic [31:0] period_offset = 32'h0000_001C;
    localparam logic [31:0] phase_shift_offset = 32'h0000_0020;

    // Written to the control register to start the modulator
    localparam logic [15:0] modulator_on_word = 16'h0028;

    //////////////////////////////////////////////////////////////////////
    // Types
    //////////////////////////////////////////////////////////////////////

    // Result of decoding a write address
    typedef enum logic [2:0] {
        control,
        duty,
        period,
        phase_shift,
        unmapped
    } register_kind_t;

    // One register write on the bus
    typedef struct packed {
        logic [31:0] address;
        logic [15:0] data;
    } pwm_write_t;

    // Registers held for each phase
    typedef struct packed {
        logic [15:0] period;
        logic [15:0] phase_shift;
        logic [15:0] duty;
    } phase_regs_t;

    typedef phase_regs_t [buck_pkg::n_phases-1:0] pwm_phase_regs_t;

endpackage

// File: hw/pwm_register_bank.sv
// Modulator register bank
`timescale 1ns/10ps

module pwm_register_bank (
    input  logic                          clock,
    input  logic                          reset,
    input  pwm_map_pkg::pwm_write_t       write,
    input  logic                          write_valid,
    output logic                          write_ready,
    output pwm_map_pkg::pwm_phase_regs_t  phase_regs,
    output logic                          modulator_on
);

    pwm_map_pkg::register_kind_t kind;
    buck_pkg::phase_index_t      phase;
    logic [31:0]                 relative_address;
    logic [31:0]                 block_index;
    logic [31:0]                 block_offset;
    logic                        transfer;

    assign transfer = write_valid && write_ready;

    //////////////////////////////////////////////////////////////////////
    // Address decode
    //////////////////////////////////////////////////////////////////////

    // Block 0 holds the control register, blocks 1 to n_phases the phases
    always_comb begin
        relative_address = write.address - pwm_map_pkg::pwm_base_address;
        block_index = relative_address / pwm_map_pkg::phase_block_stride;
        block_offset = relative_address % pwm_map_pkg::phase_block_stride;
        phase = buck_pkg::phase_index_t'(block_index - 32'd1);
        kind = pwm_map_pkg::unmapped;

        if (block_index == 32'd0) begin
            if (block_offset == 32'd0) begin
                kind = pwm_map_pkg::control;
            end
        end else if (block_index <= 32'(buck_pkg::n_phases)) begin
            case (block_offset)
                pwm_map_pkg::duty_offset:        kind = pwm_map_pkg::duty;
                pwm_map_pkg::period_offset:      kind = pwm_map_pkg::period;
                pwm_map_pkg::phase_shift_offset: kind = pwm_map_pkg::phase_shift;
                default:                         kind = pwm_map_pkg::unmapped;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Register storage
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!reset) begin
            phase_regs <= '0;
            modulator_on <= 1'b0;
            write_ready <= 1'b1;
        end else begin
            // One busy cycle follows every accepted write
            write_ready <= !transfer;

            if (transfer) begin
                case (kind)
                    pwm_map_pkg::control: begin
                        modulator_on <= (write.data == pwm_map_pkg::modulator_on_word);
                    end
                    pwm_map_pkg::duty: begin
                        phase_regs[phase].duty <= write.data;
                    end
                    pwm_map_pkg::period: begin
                        phase_regs[phase].period <= write.data;
                    end
                    pwm_map_pkg::phase_shift: begin
                        phase_regs[phase].phase_shift <= write.data;
                    end
                    // Unmapped addresses are accepted and the data is dropped
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

// File: tb.f
hw/buck_pkg.sv
hw/pwm_map_pkg.sv
hw/phase_duty_calc.sv
hw/operating_sequencer.sv
hw/pwm_register_bank.sv
hw/buck_control_top.sv
testbench/buck_control_assert.sv
testbench/buck_control_tb.sv

// File: testbench/buck_control_assert.sv
// Write bus checks
`timescale 1ns/10ps

module buck_control_assert (
    input logic                     clock,
    input logic                     reset,
    input pwm_map_pkg::pwm_write_t  write,
    input logic                     write_valid,
    input logic                     write_ready
);

    //////////////////////////////////////////////////////////////////////
    // Handshake
    //////////////////////////////////////////////////////////////////////

    // A write that is held off by the bank must not change or vanish
    hold_while_stalled: assert property (
        @(posedge clock) disable iff (!reset)
        (write_valid && !write_ready) |=> (write_valid && $stable(write))
    ) else $error("write bus changed while stalled");

    // The bank takes one busy cycle after every transfer
    busy_after_transfer: assert property (
        @(posedge clock) disable iff (!reset)
        (write_valid && write_ready) |=> !write_ready
    ) else $error("write_ready high right after a transfer");

    //////////////////////////////////////////////////////////////////////
    // Reset
    //////////////////////////////////////////////////////////////////////

    // Reset is synchronous, so the bus is idle from the edge after it is seen
    idle_in_reset: assert property (
        @(posedge clock) !reset |=> !write_valid
    ) else $error("write_valid high during reset");

endmodule

// File: testbench/buck_control_tb.sv
// Buck control testbench
`timescale 1ns/10ps

module buck_control_tb;

    typedef enum logic [1:0] {
        op_start,
        op_update,
        op_stop,
        op_update_while_stopped
    } operation_t;

    typedef struct packed {
        operation_t                  op;
        buck_pkg::setpoint_t         setpoint;
        buck_pkg::phase_word_array_t adjust;
        buck_pkg::phase_word_array_t shifts;
    } scenario_t;

    localparam int busy_timeout = 200;
    localparam int quiet_cycles = 10;

    logic                         clock;
    logic                         reset;
    logic                         start;
    logic                         stop;
    logic                         update;
    logic                         config_done;
    buck_pkg::setpoint_t          setpoint;
    buck_pkg::phase_word_array_t  duty_adjust;
    buck_pkg::phase_word_array_t  phase_shifts;
    logic                         modulator_status;
    logic                         busy;
    logic                         modulator_on;
    pwm_map_pkg::pwm_phase_regs_t phase_regs;

    pwm_map_pkg::pwm_phase_regs_t expected_regs;
    logic                         expected_running;
    scenario_t                    scenarios[$];
    integer                       seed;
    int                           errors;
    int                           tests_run;
    int                           tests_failed;

    buck_control_top dut (
        .clock(clock), .reset(reset), .start(start), .stop(stop), .update(update),
        .config_done(config_done), .setpoint(setpoint), .duty_adjust(duty_adjust),
        .phase_shifts(phase_shifts), .modulator_status(modulator_status), .busy(busy),
        .modulator_on(modulator_on), .phase_regs(phase_regs)
    );

    bind operating_sequencer buck_control_assert write_checks (
        .clock(clock), .reset(reset), .write(write),
        .write_valid(write_valid), .write_ready(write_ready)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    //////////////////////////////////////////////////////////////////////
    // Expected values
    //////////////////////////////////////////////////////////////////////

    // Common duty plus signed adjustment, held inside 0 to 0xFFFF
    function automatic logic [15:0] clamped_duty(input logic [15:0] duty,
                                                 input logic [15:0] adjust);
        int common;
        int offset;
        int sum;
        common = duty;
        offset = shortint'(adjust);
        sum = common + offset;
        if (sum < 0) return 16'h0000;
        if (sum > 65535) return 16'hFFFF;
        return 16'(sum);
    endfunction

    function automatic buck_pkg::phase_word_array_t random_adjustments();
        buck_pkg::phase_word_array_t words;
        for (int p = 0; p < buck_pkg::n_phases; p++) words[p] = 16'($random(seed) % 1024);
        return words;
    endfunction

    function automatic buck_pkg::phase_word_array_t random_shifts();
        buck_pkg::phase_word_array_t words;
        for (int p = 0; p < buck_pkg::n_phases; p++) words[p] = 16'($random(seed)) & 16'h0FFF;
        return words;
    endfunction

    function automatic string op_label(input operation_t op);
        case (op)
            op_start:  return "start";
            op_update: return "update";
            op_stop:   return "stop";
            default:   return "update_while_stopped";
        endcase
    endfunction

    // Word lists are written phase 3 first, phase 0 last
    task automatic build_scenarios();
        scenarios.push_back('{op_start, '{16'd1000, 16'd400},
            {16'hFFD8, 16'd30, 16'hFFEC, 16'd10}, {16'd750, 16'd500, 16'd250, 16'd0}});
        scenarios.push_back('{op_update, '{16'd1200, 16'd600},
            random_adjustments(), random_shifts()});
        scenarios.push_back('{op_update, '{16'd1300, 16'hFFF0},
            {16'h0000, 16'hFFE0, 16'h0010, 16'h0100}, random_shifts()});
        scenarios.push_back('{op_update, '{16'd1400, 16'h0010},
            {16'h0005, 16'h8000, 16'hFFF0, 16'hFFE0}, random_shifts()});
        scenarios.push_back('{op_stop, '{16'd0, 16'd0}, '0, '0});
        scenarios.push_back('{op_update_while_stopped, '{16'd77, 16'd77},
            random_adjustments(), random_shifts()});
        scenarios.push_back('{op_start, '{16'd2000, 16'd1000},
            random_adjustments(), random_shifts()});
        scenarios.push_back('{op_stop, '{16'd0, 16'd0}, '0, '0});
    endtask

    task automatic predict(input scenario_t row);
        for (int p = 0; p < buck_pkg::n_phases; p++) begin
            if (row.op == op_start || (row.op == op_update && expected_running)) begin
                expected_regs[p].period = row.setpoint.period;
                expected_regs[p].duty = clamped_duty(row.setpoint.duty, row.adjust[p]);
            end
            if (row.op == op_start) expected_regs[p].phase_shift = row.shifts[p];
        end
        if (row.op == op_start) expected_running = 1'b1;
        if (row.op == op_stop) expected_running = 1'b0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    task automatic compare_phase_regs(input pwm_map_pkg::pwm_phase_regs_t actual,
                                      input pwm_map_pkg::pwm_phase_regs_t expected);
        for (int p = 0; p < buck_pkg::n_phases; p++) begin
            if (actual[p] !== expected[p]) begin
                $display("Mismatch at %0t: phase %0d period/shift/duty %h/%h/%h, expected %h/%h/%h",
                         $time, p, actual[p].period, actual[p].phase_shift, actual[p].duty,
                         expected[p].period, expected[p].phase_shift, expected[p].duty);
                errors++;
            end
        end
    endtask

    task automatic compare_bit(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s is %b, expected %b", $time, what, actual, expected);
            errors++;
        end
    endtask

    task automatic wait_for_busy(input logic level, input string label);
        int cycles;
        cycles = 0;
        while (busy !== level && cycles < busy_timeout) begin
            @(negedge clock);
            cycles++;
        end
        if (busy !== level) begin
            $display("Timeout in %s: busy did not become %b within %0d cycles",
                     label, level, busy_timeout);
            errors++;
        end
    endtask

    task automatic finish_test(input string label, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("Test %0d %s: ok", tests_run, label);
        end else begin
            tests_failed++;
            $display("Test %0d %s: failed", tests_run, label);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic run_scenario(input scenario_t row);
        int errors_before;
        string label;
        errors_before = errors;
        label = op_label(row.op);
        @(negedge clock);
        setpoint = row.setpoint;
        duty_adjust = row.adjust;
        phase_shifts = row.shifts;
        @(negedge clock);
        start = (row.op == op_start);
        stop = (row.op == op_stop);
        update = (row.op == op_update || row.op == op_update_while_stopped);
        @(negedge clock);
        start = 1'b0;
        stop = 1'b0;
        update = 1'b0;
        predict(row);
        if (row.op == op_update_while_stopped) begin
            // Nothing may start when the modulator is off
            for (int i = 0; i < quiet_cycles; i++) begin
                compare_bit(busy, 1'b0, "busy");
                @(negedge clock);
            end
        end else begin
            wait_for_busy(1'b1, label);
            if (row.op == op_start) begin
                repeat (3) @(negedge clock);
                config_done = 1'b1;
            end
            wait_for_busy(1'b0, label);
            config_done = 1'b0;
        end
        compare_phase_regs(phase_regs, expected_regs);
        compare_bit(modulator_on, expected_running, "modulator_on");
        compare_bit(modulator_status, expected_running, "modulator_status");
        finish_test(label, errors_before);
    endtask

    initial begin
        seed = 12;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        reset = 1'b0;
        start = 1'b0;
        stop = 1'b0;
        update = 1'b0;
        config_done = 1'b0;
        setpoint = '0;
        duty_adjust = '0;
        phase_shifts = '0;
        expected_regs = '0;
        expected_running = 1'b0;
        build_scenarios();

        repeat (5) @(posedge clock);
        @(negedge clock);
        reset = 1'b1;
        compare_phase_regs(phase_regs, expected_regs);
        compare_bit(modulator_on, 1'b0, "modulator_on");
        compare_bit(modulator_status, 1'b0, "modulator_status");
        compare_bit(busy, 1'b0, "busy");
        finish_test("reset", 0);

        for (int i = 0; i < scenarios.size(); i++) run_scenario(scenarios[i]);

        $display("Tests run %0d, tests failed %0d, checks failed %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
